// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = dcache_tb
FILELIST = vlog.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))
PASS_MSG = test passed

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/dcache_mem_model.sv
`timescale 1ns/1ps

module dcache_mem_model #(
    parameter int MEM_BYTES = 4096
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  dcache_bus_pkg::mem_req_t mem_req_i,
    output dcache_bus_pkg::mem_rsp_t mem_rsp_o,
    output int                       rd_count_o,
    output int                       wr_count_o,
    output dcache_geom_pkg::word_t   rd_addr_o,
    output dcache_geom_pkg::word_t   wr_addr_o,
    output dcache_geom_pkg::line_t   wr_line_o
);

    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    logic [7:0] mem [MEM_BYTES];
    mem_req_t   req;
    int         base;
    int         n_req;

    // Low address byte plus a term from the upper bits
    function automatic logic [7:0] pattern_byte(input int unsigned a);
        return 8'(a) + 8'(a >> 8) * 8'h3b + 8'ha5;
    endfunction

    initial begin
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = pattern_byte(a);
        end
        mem_rsp_o  = '0;
        rd_count_o = 0;
        wr_count_o = 0;
        rd_addr_o  = '0;
        wr_addr_o  = '0;
        wr_line_o  = '0;
        n_req      = 0;
        forever begin
            @(posedge clk_i);
            #1;
            // Ready lasts one cycle
            mem_rsp_o.ready = 1'b0;
            if (!rst_i && mem_req_i.strobe) begin
                req  = mem_req_i;
                base = int'(req.addr % MEM_BYTES) & ~15;
                // Latency walks through 3, 4, 5, 6
                repeat (3 + n_req % 4) @(posedge clk_i);
                #1;
                n_req++;
                if (req.we) begin
                    for (int b = 0; b < LINE_BITS / 8; b++) begin
                        mem[base + b] = req.wline[b*8 +: 8];
                    end
                    wr_count_o++;
                    wr_addr_o = req.addr;
                    wr_line_o = req.wline;
                end else begin
                    for (int b = 0; b < LINE_BITS / 8; b++) begin
                        mem_rsp_o.rline[b*8 +: 8] = mem[base + b];
                    end
                    rd_count_o++;
                    rd_addr_o = req.addr;
                end
                mem_rsp_o.ready = 1'b1;
            end
        end
    end

endmodule

// File: bench/dcache_sva.sv
`timescale 1ns/1ps

module dcache_sva (
    input logic clk_i,
    input logic rst_i,
    input logic accept_i,
    input logic ready_i,
    input logic strobe_i
);

    // Request taken, response still owed
    logic pending_q;

    // Failed checks so far
    int unsigned fail_count = 0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= 1'b0;
        end else if (accept_i) begin
            pending_q <= 1'b1;
        end else if (ready_i) begin
            pending_q <= 1'b0;
        end
    end

    // ====================
    // Handshake rules
    // ====================
    strobe_single: assert property (@(posedge clk_i) disable iff (rst_i)
        strobe_i |=> !strobe_i)
        else begin
            $error("memory strobe high for two cycles in a row");
            fail_count++;
        end

    ready_after_accept: assert property (@(posedge clk_i) disable iff (rst_i)
        ready_i |-> pending_q)
        else begin
            $error("processor ready with no accepted request");
            fail_count++;
        end

    no_accept_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        accept_i |-> !pending_q)
        else begin
            $error("request accepted while the previous one is open");
            fail_count++;
        end

endmodule

bind dcache_ctrl dcache_sva i_sva (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .accept_i(accept),
    .ready_i (cpu_rsp_o.ready),
    .strobe_i(mem_req_o.strobe)
);

// File: bench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    localparam int N_WAYS     = 2;
    localparam int MEM_BYTES  = 4096;
    // About 500 requests, at most 40 cycles each
    localparam int MAX_CYCLES = 500 * 40;
    localparam be_t BE_PATS [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                    4'b0011, 4'b1100, 4'b1111};

    logic       clk = 1'b0;
    logic       rst;
    cpu_req_t   cpu_req;
    cpu_rsp_t   cpu_rsp;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;
    int         rd_count;
    int         wr_count;
    word_t      rd_addr;
    word_t      wr_addr;
    line_t      wr_line;

    // Reference copy of memory
    logic [7:0] ref_mem [MEM_BYTES];
    logic [31:0] lfsr;
    int         cycles = 0;
    int         errors;
    int         checks;
    int         tests;
    int         failing;
    int         errs_before;

    always #5 clk = ~clk;

    dcache_top #(
        .N_WAYS(N_WAYS)
    ) i_dut (
        .clk_i    (clk),
        .rst_i    (rst),
        .cpu_req_i(cpu_req),
        .cpu_rsp_o(cpu_rsp),
        .mem_req_o(mem_req),
        .mem_rsp_i(mem_rsp)
    );

    dcache_mem_model #(
        .MEM_BYTES(MEM_BYTES)
    ) i_mem (
        .clk_i     (clk),
        .rst_i     (rst),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp),
        .rd_count_o(rd_count),
        .wr_count_o(wr_count),
        .rd_addr_o (rd_addr),
        .wr_addr_o (wr_addr),
        .wr_line_o (wr_line)
    );

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles, a request never completed", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    // ====================
    // Helpers
    // ====================
    function automatic logic [7:0] pattern_byte(input int unsigned a);
        return 8'(a) + 8'(a >> 8) * 8'h3b + 8'ha5;
    endfunction

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        bit_out;
        val = '0;
        for (int i = 0; i < n; i++) begin
            bit_out = lfsr[0];
            lfsr    = lfsr >> 1;
            if (bit_out) lfsr = lfsr ^ 32'h80200003;
            val = {val[30:0], bit_out};
        end
        return val;
    endfunction

    function automatic word_t ref_word(input word_t addr);
        word_t w;
        int    base;
        base = int'(addr[11:2]) * 4;
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = ref_mem[base + b];
        end
        return w;
    endfunction

    // Byte 0 of the line in the low bits
    function automatic line_t ref_line(input word_t addr);
        line_t l;
        int    base;
        base = int'(addr[11:4]) * 16;
        for (int b = 0; b < 16; b++) begin
            l[b*8 +: 8] = ref_mem[base + b];
        end
        return l;
    endfunction

    task automatic ref_store(input word_t addr, input be_t be, input word_t data);
        int base;
        base = int'(addr[11:2]) * 4;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) ref_mem[base + b] = data[b*8 +: 8];
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAILED with %0d errors", name, errors - errs_before);
            failing++;
        end
        errs_before = errors;
    endtask

    // One request, latency counted in cycles after the request cycle
    task automatic cpu_access(input logic we, input be_t be, input word_t addr,
                              input word_t wdata, output word_t rdata, output int lat);
        @(posedge clk);
        #1;
        cpu_req.valid    = 1'b1;
        cpu_req.we       = we;
        cpu_req.be       = be;
        cpu_req.addr.raw = addr;
        cpu_req.wdata    = wdata;
        @(posedge clk);
        #1;
        cpu_req.valid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!cpu_rsp.ready);
        rdata = cpu_rsp.rdata;
    endtask

    // ====================
    // Tests
    // ====================
    task automatic read_miss_refill();
        word_t data;
        int    lat;
        int    rd0;
        int    wr0;
        rd0 = rd_count;
        wr0 = wr_count;
        cpu_access(1'b0, 4'hf, 32'h124, '0, data, lat);
        check_word("read_miss_refill data", ref_word(32'h124), data);
        check_word("read_miss_refill line reads", rd0 + 1, rd_count);
        check_word("read_miss_refill line writes", wr0, wr_count);
        check_word("read_miss_refill read addr", 32'h120, rd_addr);
        report_test("read_miss_refill");
    endtask

    task automatic read_hit();
        word_t data;
        int    lat;
        cpu_access(1'b0, 4'hf, 32'h12c, '0, data, lat);
        check_word("read_hit data", ref_word(32'h12c), data);
        check_word("read_hit latency", 1, lat);
        // A miss would raise the strobe in the cycle after the lookup
        @(negedge clk);
        check_word("read_hit memory strobe", 0, 32'(mem_req.strobe));
        report_test("read_hit");
    endtask

    // Store each legal pattern into a cached word, read it back
    task automatic byte_enable_store();
        word_t wdata;
        word_t data;
        int    lat;
        int    traffic;
        traffic = rd_count + wr_count;
        for (int p = 0; p < 7; p++) begin
            wdata = rand_bits(32);
            cpu_access(1'b1, BE_PATS[p], 32'h128, wdata, data, lat);
            ref_store(32'h128, BE_PATS[p], wdata);
            check_word("byte_enable_store store latency", 1, lat);
            cpu_access(1'b0, 4'hf, 32'h128, '0, data, lat);
            check_word("byte_enable_store data", ref_word(32'h128), data);
        end
        check_word("byte_enable_store memory requests", traffic, rd_count + wr_count);
        report_test("byte_enable_store");
    endtask

    // Set 6 filled past its ways, dirty line leaves first
    task automatic fifo_evict_writeback();
        word_t base;
        word_t addr;
        word_t wdata;
        word_t data;
        line_t exp_line;
        int    lat;
        int    wr0;
        int    rd0;
        base  = 32'h364;
        wdata = rand_bits(32);
        cpu_access(1'b1, 4'hf, base, wdata, data, lat);
        ref_store(base, 4'hf, wdata);
        exp_line = ref_line(base);
        wr0 = wr_count;
        for (int k = 1; k <= N_WAYS; k++) begin
            addr = base + 32'(k) * 32'h100;
            cpu_access(1'b0, 4'hf, addr, '0, data, lat);
            check_word("fifo_evict_writeback fill data", ref_word(addr), data);
        end
        check_word("fifo_evict_writeback line writes", wr0 + 1, wr_count);
        check_word("fifo_evict_writeback write addr", 32'h360, wr_addr);
        check_line("fifo_evict_writeback write line", exp_line, wr_line);
        // Evicted line comes back from memory
        rd0 = rd_count;
        cpu_access(1'b0, 4'hf, base, '0, data, lat);
        check_word("fifo_evict_writeback reread data", ref_word(base), data);
        check_word("fifo_evict_writeback reread refill", rd0 + 1, rd_count);
        report_test("fifo_evict_writeback");
    endtask

    task automatic store_miss_allocate();
        word_t wdata;
        word_t data;
        int    lat;
        int    rd0;
        rd0   = rd_count;
        wdata = rand_bits(32);
        cpu_access(1'b1, 4'b0110, 32'h7a8, wdata, data, lat);
        ref_store(32'h7a8, 4'b0110, wdata);
        check_word("store_miss_allocate refill", rd0 + 1, rd_count);
        cpu_access(1'b0, 4'hf, 32'h7a8, '0, data, lat);
        check_word("store_miss_allocate stored word", ref_word(32'h7a8), data);
        check_word("store_miss_allocate stored latency", 1, lat);
        cpu_access(1'b0, 4'hf, 32'h7ac, '0, data, lat);
        check_word("store_miss_allocate neighbour word", ref_word(32'h7ac), data);
        check_word("store_miss_allocate neighbour latency", 1, lat);
        report_test("store_miss_allocate");
    endtask

    task automatic random_mix();
        logic  we;
        word_t addr;
        word_t wdata;
        word_t data;
        be_t   be;
        int    lat;
        for (int i = 0; i < 400; i++) begin
            we    = (rand_bits(1) != 0);
            addr  = rand_bits(10) << 2;
            be    = BE_PATS[int'(rand_bits(3) % 7)];
            wdata = rand_bits(32);
            cpu_access(we, be, addr, wdata, data, lat);
            if (we) begin
                ref_store(addr, be, wdata);
            end else begin
                check_word("random_mix read", ref_word(addr), data);
            end
        end
        report_test("random_mix");
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        lfsr        = 32'hc8f430d1;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        failing     = 0;
        errs_before = 0;
        rst         = 1'b1;
        cpu_req     = '0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            ref_mem[a] = pattern_byte(a);
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        read_miss_refill();
        read_hit();
        byte_enable_store();
        fifo_evict_writeback();
        store_miss_allocate();
        random_mix();

        // Handshake rules checked alongside the tests
        if (i_dut.i_ctrl.i_sva.fail_count != 0) begin
            $display("Bound assertions fired %0d times", i_dut.i_ctrl.i_sva.fail_count);
            errors += int'(i_dut.i_ctrl.i_sva.fail_count);
        end

        $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 tests, failing, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: hdl/dcache_bus_pkg.sv
package dcache_bus_pkg;

    // Processor request, valid for one cycle
    typedef struct packed {
        logic                   valid;
        logic                   we;
        dcache_geom_pkg::be_t   be;
        dcache_geom_pkg::addr_u addr;
        dcache_geom_pkg::word_t wdata;
    } cpu_req_t;

    // One-cycle ready, rdata valid with it on reads
    typedef struct packed {
        logic                   ready;
        dcache_geom_pkg::word_t rdata;
    } cpu_rsp_t;

    // Line request to memory
    // Strobe is a pulse, the rest holds until the response
    typedef struct packed {
        logic                   strobe;
        logic                   we;
        dcache_geom_pkg::word_t addr;
        dcache_geom_pkg::line_t wline;
    } mem_req_t;

    typedef struct packed {
        logic                   ready;
        dcache_geom_pkg::line_t rline;
    } mem_rsp_t;

    // Controller to way storage
    typedef struct packed {
        logic [dcache_geom_pkg::INDEX_BITS-1:0] index;
        logic [dcache_geom_pkg::TAG_BITS-1:0]   tag;
        logic [dcache_geom_pkg::MAX_WAYS-1:0]   way_we;
        logic                                   dirty;
        dcache_geom_pkg::line_t                 wline;
    } way_lookup_t;

endpackage

// File: hdl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int N_WAYS = 2
) (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  dcache_bus_pkg::cpu_req_t                cpu_req_i,
    output dcache_bus_pkg::cpu_rsp_t                cpu_rsp_o,
    output dcache_bus_pkg::mem_req_t                mem_req_o,
    input  dcache_bus_pkg::mem_rsp_t                mem_rsp_i,
    output dcache_bus_pkg::way_lookup_t             way_lookup_o,
    output logic                                    fill_done_o,
    input  logic                                    way_hit_i,
    input  logic [$clog2(N_WAYS)-1:0]               hit_way_i,
    input  logic [$clog2(N_WAYS)-1:0]               victim_way_i,
    input  logic [dcache_geom_pkg::TAG_BITS-1:0]    victim_tag_i,
    input  logic                                    victim_dirty_i,
    input  dcache_geom_pkg::line_t                  hit_line_i,
    input  dcache_geom_pkg::line_t                  victim_line_i,
    output dcache_geom_pkg::line_t                  merge_line_o,
    output logic [dcache_geom_pkg::OFFSET_BITS-1:0] merge_offset_o,
    output dcache_geom_pkg::word_t                  merge_wdata_o,
    output dcache_geom_pkg::be_t                    merge_be_o,
    input  dcache_geom_pkg::word_t                  merge_word_i,
    input  dcache_geom_pkg::line_t                  merge_line_i
);

    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    localparam int WAY_W = $clog2(N_WAYS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WRITE_BACK,
        S_REFILL_WAIT,
        S_REFILL_DONE
    } state_t;

    state_t   state_q;
    state_t   state_d;
    cpu_req_t req_q;
    line_t    fill_q;
    logic     accept;
    logic     store_hit;
    logic     refill_done;
    logic     issue_wb;
    logic     issue_rd;
    logic     mem_strobe_q;
    logic     mem_we_q;
    word_t    mem_addr_q;
    line_t    mem_wline_q;
    addr_u    wb_addr;
    addr_u    rd_addr;

    assign accept      = (state_q == S_IDLE) && cpu_req_i.valid;
    assign store_hit   = (state_q == S_LOOKUP) && way_hit_i && req_q.we;
    assign refill_done = (state_q == S_REFILL_DONE);

    // ====================
    // FSM
    // ====================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            S_IDLE: begin
                if (accept) state_d = S_LOOKUP;
            end
            // Tag compare result arrives here
            S_LOOKUP: begin
                if (way_hit_i) begin
                    state_d = S_IDLE;
                end else begin
                    state_d = victim_dirty_i ? S_WRITE_BACK : S_REFILL_WAIT;
                end
            end
            S_WRITE_BACK: begin
                if (mem_rsp_i.ready) state_d = S_REFILL_WAIT;
            end
            S_REFILL_WAIT: begin
                if (mem_rsp_i.ready) state_d = S_REFILL_DONE;
            end
            default: state_d = S_IDLE;
        endcase
    end

    // Request and refill line capture
    always_ff @(posedge clk_i) begin
        if (accept) req_q <= cpu_req_i;
        if ((state_q == S_REFILL_WAIT) && mem_rsp_i.ready) fill_q <= mem_rsp_i.rline;
    end

    // ====================
    // Memory port
    // ====================
    // Victim line address, or line-aligned request address
    always_comb begin
        wb_addr.f          = '{tag: victim_tag_i, index: req_q.addr.f.index,
                               offset: '0, byte_off: '0};
        rd_addr.raw        = req_q.addr.raw;
        rd_addr.f.offset   = '0;
        rd_addr.f.byte_off = '0;
    end

    // Dirty victim first, refill after its ready
    assign issue_wb = (state_q == S_LOOKUP) && !way_hit_i && victim_dirty_i;
    assign issue_rd = ((state_q == S_LOOKUP) && !way_hit_i && !victim_dirty_i) ||
                      ((state_q == S_WRITE_BACK) && mem_rsp_i.ready);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mem_strobe_q <= 1'b0;
        end else begin
            mem_strobe_q <= issue_wb || issue_rd;
        end
    end

    // Held stable until the memory answers
    always_ff @(posedge clk_i) begin
        if (issue_wb) begin
            mem_we_q    <= 1'b1;
            mem_addr_q  <= wb_addr.raw;
            mem_wline_q <= victim_line_i;
        end else if (issue_rd) begin
            mem_we_q   <= 1'b0;
            mem_addr_q <= rd_addr.raw;
        end
    end

    assign mem_req_o = '{strobe: mem_strobe_q, we: mem_we_q,
                         addr: mem_addr_q, wline: mem_wline_q};

    // ====================
    // Way writes and merge
    // ====================
    assign merge_line_o   = refill_done ? fill_q : hit_line_i;
    assign merge_offset_o = req_q.addr.f.offset;
    assign merge_wdata_o  = req_q.wdata;
    assign merge_be_o     = req_q.be;

    always_comb begin
        way_lookup_o = '0;
        // Index straight from the bus while idle so the read starts at once
        way_lookup_o.index = (state_q == S_IDLE) ? cpu_req_i.addr.f.index
                                                 : req_q.addr.f.index;
        way_lookup_o.tag   = req_q.addr.f.tag;
        // Stores always leave the line dirty
        way_lookup_o.dirty = req_q.we;
        // Raw refill on read miss, merged line otherwise
        way_lookup_o.wline = (refill_done && !req_q.we) ? fill_q : merge_line_i;
        for (int w = 0; w < N_WAYS; w++) begin
            if (store_hit) begin
                way_lookup_o.way_we[w] = (hit_way_i == WAY_W'(w));
            end else if (refill_done) begin
                way_lookup_o.way_we[w] = (victim_way_i == WAY_W'(w));
            end
        end
    end

    assign fill_done_o = refill_done;

    // Hit answers in lookup, miss answers after refill
    assign cpu_rsp_o.ready = ((state_q == S_LOOKUP) && way_hit_i) || refill_done;
    assign cpu_rsp_o.rdata = merge_word_i;

endmodule

// File: hdl/dcache_geom_pkg.sv
package dcache_geom_pkg;

    // ====================
    // Word and line sizes
    // ====================
    localparam int XLEN        = 32;
    localparam int LINE_WORDS  = 4;
    localparam int LINE_BITS   = XLEN * LINE_WORDS;

    // ====================
    // Address split
    // ====================
    // Byte inside word, word inside line, then set index and tag
    localparam int BYTE_BITS   = 2;
    localparam int OFFSET_BITS = $clog2(LINE_WORDS);
    localparam int INDEX_BITS  = 4;
    localparam int N_SETS      = 1 << INDEX_BITS;
    localparam int TAG_BITS    = XLEN - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    // Widest associativity the way-enable field can carry
    localparam int MAX_WAYS    = 4;

    typedef logic [XLEN-1:0]      word_t;
    // Word 0 sits in the low bits
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [XLEN/8-1:0]    be_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
        logic [BYTE_BITS-1:0]   byte_off;
    } addr_fields_t;

    // Flat word towards memory, split fields inside the cache
    typedef union packed {
        word_t        raw;
        addr_fields_t f;
    } addr_u;

endpackage

// File: hdl/dcache_merge.sv
`timescale 1ns/1ps

module dcache_merge (
    input  dcache_geom_pkg::line_t                  line_i,
    input  logic [dcache_geom_pkg::OFFSET_BITS-1:0] offset_i,
    input  dcache_geom_pkg::word_t                  wdata_i,
    input  dcache_geom_pkg::be_t                    be_i,
    output dcache_geom_pkg::word_t                  word_o,
    output dcache_geom_pkg::line_t                  line_o
);

    import dcache_geom_pkg::*;

    word_t words [LINE_WORDS];
    word_t merged;

    // ====================
    // Word select
    // ====================
    // Split the line, word 0 lowest
    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            words[w] = line_i[w*XLEN +: XLEN];
        end
    end

    // Read data for the addressed word
    assign word_o = words[offset_i];

    // ====================
    // Byte merge
    // ====================
    // Enabled bytes from the store, the rest kept
    always_comb begin
        for (int b = 0; b < XLEN/8; b++) begin
            merged[b*8 +: 8] = be_i[b] ? wdata_i[b*8 +: 8] : word_o[b*8 +: 8];
        end
    end

    // Rebuild the line around the merged word
    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            if (offset_i == OFFSET_BITS'(w)) begin
                line_o[w*XLEN +: XLEN] = merged;
            end else begin
                line_o[w*XLEN +: XLEN] = words[w];
            end
        end
    end

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int N_WAYS = 2
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  dcache_bus_pkg::cpu_req_t cpu_req_i,
    output dcache_bus_pkg::cpu_rsp_t cpu_rsp_o,
    output dcache_bus_pkg::mem_req_t mem_req_o,
    input  dcache_bus_pkg::mem_rsp_t mem_rsp_i
);

    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;

    localparam int WAY_W = $clog2(N_WAYS);

    // ====================
    // Controller to ways
    // ====================
    way_lookup_t         lookup;
    logic                fill_done;
    logic                way_hit;
    logic [WAY_W-1:0]    hit_way;
    logic [WAY_W-1:0]    victim_way;
    logic [TAG_BITS-1:0] victim_tag;
    logic                victim_dirty;
    line_t               hit_line;
    line_t               victim_line;

    // ====================
    // Controller to merge
    // ====================
    line_t                  merge_line_in;
    logic [OFFSET_BITS-1:0] merge_offset;
    word_t                  merge_wdata;
    be_t                    merge_be;
    word_t                  merge_word;
    line_t                  merge_line_out;

    dcache_ctrl #(
        .N_WAYS(N_WAYS)
    ) i_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .cpu_req_i     (cpu_req_i),
        .cpu_rsp_o     (cpu_rsp_o),
        .mem_req_o     (mem_req_o),
        .mem_rsp_i     (mem_rsp_i),
        .way_lookup_o  (lookup),
        .fill_done_o   (fill_done),
        .way_hit_i     (way_hit),
        .hit_way_i     (hit_way),
        .victim_way_i  (victim_way),
        .victim_tag_i  (victim_tag),
        .victim_dirty_i(victim_dirty),
        .hit_line_i    (hit_line),
        .victim_line_i (victim_line),
        .merge_line_o  (merge_line_in),
        .merge_offset_o(merge_offset),
        .merge_wdata_o (merge_wdata),
        .merge_be_o    (merge_be),
        .merge_word_i  (merge_word),
        .merge_line_i  (merge_line_out)
    );

    dcache_ways #(
        .N_WAYS(N_WAYS)
    ) i_ways (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .way_lookup_i  (lookup),
        .fill_done_i   (fill_done),
        .way_hit_o     (way_hit),
        .hit_way_o     (hit_way),
        .victim_way_o  (victim_way),
        .victim_tag_o  (victim_tag),
        .victim_dirty_o(victim_dirty),
        .hit_line_o    (hit_line),
        .victim_line_o (victim_line)
    );

    dcache_merge i_merge (
        .line_i  (merge_line_in),
        .offset_i(merge_offset),
        .wdata_i (merge_wdata),
        .be_i    (merge_be),
        .word_o  (merge_word),
        .line_o  (merge_line_out)
    );

endmodule

// File: hdl/dcache_ways.sv
`timescale 1ns/1ps

module dcache_ways #(
    parameter int N_WAYS = 2
) (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  dcache_bus_pkg::way_lookup_t          way_lookup_i,
    input  logic                                 fill_done_i,
    output logic                                 way_hit_o,
    output logic [$clog2(N_WAYS)-1:0]            hit_way_o,
    output logic [$clog2(N_WAYS)-1:0]            victim_way_o,
    output logic [dcache_geom_pkg::TAG_BITS-1:0] victim_tag_o,
    output logic                                 victim_dirty_o,
    output dcache_geom_pkg::line_t               hit_line_o,
    output dcache_geom_pkg::line_t               victim_line_o
);

    import dcache_geom_pkg::*;

    localparam int WAY_W = $clog2(N_WAYS);

    // ====================
    // Storage
    // ====================
    logic [TAG_BITS-1:0] tag_mem  [N_WAYS][N_SETS];
    line_t               line_mem [N_WAYS][N_SETS];
    logic [N_SETS-1:0]   valid_q  [N_WAYS];
    logic [N_SETS-1:0]   dirty_q  [N_WAYS];
    // Per-set FIFO pointer, names the next victim
    logic [WAY_W-1:0]    fifo_q   [N_SETS];

    // Registered read side
    logic [TAG_BITS-1:0] tag_rd  [N_WAYS];
    line_t               line_rd [N_WAYS];
    logic [N_WAYS-1:0]   valid_rd;
    logic [N_WAYS-1:0]   dirty_rd;
    logic [WAY_W-1:0]    victim_q;
    logic [N_WAYS-1:0]   hit_vec;

    // Tag and data arrays, read one cycle after the index
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < N_WAYS; w++) begin
            if (way_lookup_i.way_we[w]) begin
                tag_mem[w][way_lookup_i.index]  <= way_lookup_i.tag;
                line_mem[w][way_lookup_i.index] <= way_lookup_i.wline;
            end
            tag_rd[w]  <= tag_mem[w][way_lookup_i.index];
            line_rd[w] <= line_mem[w][way_lookup_i.index];
        end
    end

    // Valid, dirty and FIFO state
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int w = 0; w < N_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            for (int s = 0; s < N_SETS; s++) begin
                fifo_q[s] <= '0;
            end
            valid_rd <= '0;
            dirty_rd <= '0;
            victim_q <= '0;
        end else begin
            for (int w = 0; w < N_WAYS; w++) begin
                if (way_lookup_i.way_we[w]) begin
                    valid_q[w][way_lookup_i.index] <= 1'b1;
                    dirty_q[w][way_lookup_i.index] <= way_lookup_i.dirty;
                end
                valid_rd[w] <= valid_q[w][way_lookup_i.index];
                dirty_rd[w] <= dirty_q[w][way_lookup_i.index];
            end
            // Wraps at N_WAYS
            if (fill_done_i) fifo_q[way_lookup_i.index] <= fifo_q[way_lookup_i.index] + 1'b1;
            victim_q <= fifo_q[way_lookup_i.index];
        end
    end

    // ====================
    // Hit and victim
    // ====================
    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            hit_vec[w] = valid_rd[w] && (tag_rd[w] == way_lookup_i.tag);
            if (hit_vec[w]) hit_way_o = WAY_W'(w);
        end
    end

    assign way_hit_o      = |hit_vec;
    assign hit_line_o     = line_rd[hit_way_o];
    assign victim_way_o   = victim_q;
    assign victim_tag_o   = tag_rd[victim_q];
    // Empty way never needs a write-back
    assign victim_dirty_o = valid_rd[victim_q] && dirty_rd[victim_q];
    assign victim_line_o  = line_rd[victim_q];

endmodule

// File: vlog.f
hdl/dcache_geom_pkg.sv
hdl/dcache_bus_pkg.sv
hdl/dcache_merge.sv
hdl/dcache_ways.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_sva.sv
bench/dcache_tb.sv
